// ==== logic/uart_bus_pkg.sv ====
package uart_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register bus geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned BusAddrWidth = 5;   // Byte address into the block
  localparam int unsigned BusDataWidth = 32;  // Full bus word
  localparam int unsigned RegWidth     = 8;   // Every UART register is one byte
  localparam int unsigned WordIdxWidth = 3;   // Address bits 4 down to 2

  ////////////////////////////////////////////////////////////////////////////
  // Register offsets as word index
  ////////////////////////////////////////////////////////////////////////////

  // Bank selected by DLAB clear
  localparam logic [WordIdxWidth-1:0] THR_OFFSET = 3'd0;  // Transmit holding
  localparam logic [WordIdxWidth-1:0] IER_OFFSET = 3'd1;

  // Bank selected by DLAB set, same slots as THR and IER
  localparam logic [WordIdxWidth-1:0] DLL_OFFSET = 3'd0;  // Divisor low byte
  localparam logic [WordIdxWidth-1:0] DLM_OFFSET = 3'd1;  // Divisor high byte

  // Visible in both banks
  localparam logic [WordIdxWidth-1:0] LCR_OFFSET = 3'd3;
  localparam logic [WordIdxWidth-1:0] LSR_OFFSET = 3'd5;  // Read only
  localparam logic [WordIdxWidth-1:0] SPR_OFFSET = 3'd7;  // Scratch

endpackage

// ==== logic/uart_line_pkg.sv ====
package uart_line_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Line control and status bits
  ////////////////////////////////////////////////////////////////////////////

  // LCR fields
  localparam int unsigned LcrDlabBit   = 7;  // Divisor latch access
  localparam int unsigned LcrParityBit = 3;  // Even parity bit appended when set

  // LSR fields, built live from FIFO and serializer state
  localparam int unsigned LsrThreBit = 5;  // Holding FIFO empty
  localparam int unsigned LsrTemtBit = 6;  // FIFO empty and line idle

  ////////////////////////////////////////////////////////////////////////////
  // Transmit buffering and baud
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned TxFifoDepth    = 4;  // Entries, power of two
  localparam int unsigned TxFifoPtrWidth = 2;  // log2 of the depth

  // DLM concatenated with DLL
  localparam int unsigned DivisorWidth = 16;

  // Each serial bit holds for divisor plus one clock cycles
  // Frame is start, eight data bits LSB first, optional parity, one stop

endpackage

// ==== logic/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  // Request phase
  input  logic                                   bus_req_i,
  input  logic                                   bus_we_i,
  input  logic [uart_bus_pkg::BusAddrWidth-1:0]  bus_addr_i,
  input  logic [uart_bus_pkg::BusDataWidth-1:0]  bus_wdata_i,
  output logic                                   bus_gnt_o,
  // Response phase, one cycle after grant
  output logic                                   bus_rvalid_o,
  output logic [uart_bus_pkg::BusDataWidth-1:0]  bus_rdata_o,
  output logic                                   bus_err_o,
  // Toward the transmit path
  output logic                                   push_valid_o,
  output logic [uart_bus_pkg::RegWidth-1:0]      push_data_o,
  output logic [uart_line_pkg::DivisorWidth-1:0] divisor_o,
  output logic                                   parity_en_o,
  input  logic                                   fifo_full_i,
  input  logic                                   fifo_empty_i,
  input  logic                                   tx_busy_i
);

  logic [uart_bus_pkg::RegWidth-1:0]     ier_q, lcr_q, dll_q, dlm_q, spr_q;
  logic [uart_bus_pkg::RegWidth-1:0]     lsr;      // Live status, never stored
  logic [uart_bus_pkg::RegWidth-1:0]     rd_byte;
  logic [uart_bus_pkg::WordIdxWidth-1:0] word_d, word_q;
  logic                                  req_q, we_q;  // Held for the response
  logic                                  w_err_d, w_err_q;
  logic                                  r_err;
  logic                                  dlab;
  logic                                  thr_sel;
  logic                                  ier_we, lcr_we, dll_we, dlm_we, spr_we;

  ////////////////////////////////////////////////////////////////////////////
  // Request phase decode
  ////////////////////////////////////////////////////////////////////////////

  assign bus_gnt_o = bus_req_i;  // Never stalls
  assign word_d    = bus_addr_i[uart_bus_pkg::WordIdxWidth+1:2];  // 32-bit aligned
  assign dlab      = lcr_q[uart_line_pkg::LcrDlabBit];

  always_comb begin
    thr_sel = 1'b0;
    ier_we  = 1'b0;
    lcr_we  = 1'b0;
    dll_we  = 1'b0;
    dlm_we  = 1'b0;
    spr_we  = 1'b0;
    w_err_d = 1'b0;
    if (bus_req_i && bus_we_i) begin
      if (!dlab) begin  // Data bank
        case (word_d)
          uart_bus_pkg::THR_OFFSET: thr_sel = 1'b1;
          uart_bus_pkg::IER_OFFSET: ier_we  = 1'b1;
          uart_bus_pkg::LCR_OFFSET: lcr_we  = 1'b1;
          uart_bus_pkg::SPR_OFFSET: spr_we  = 1'b1;
          default:                  w_err_d = 1'b1;  // LSR or hole
        endcase
      end else begin  // Divisor bank
        case (word_d)
          uart_bus_pkg::DLL_OFFSET: dll_we  = 1'b1;
          uart_bus_pkg::DLM_OFFSET: dlm_we  = 1'b1;
          uart_bus_pkg::LCR_OFFSET: lcr_we  = 1'b1;  // Needed to leave DLAB
          uart_bus_pkg::SPR_OFFSET: spr_we  = 1'b1;
          default:                  w_err_d = 1'b1;
        endcase
      end
      // Full FIFO drops the byte and flags it
      if (thr_sel && fifo_full_i) begin
        w_err_d = 1'b1;
      end
    end
  end

  assign push_valid_o = thr_sel & ~fifo_full_i;  // FIFO takes it on the next edge
  assign push_data_o  = bus_wdata_i[uart_bus_pkg::RegWidth-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ier_q   <= '0;
      lcr_q   <= '0;
      dll_q   <= 8'd1;  // Divisor starts at 1
      dlm_q   <= '0;
      spr_q   <= '0;
      req_q   <= 1'b0;
      we_q    <= 1'b0;
      word_q  <= '0;
      w_err_q <= 1'b0;
    end else begin
      if (ier_we) ier_q <= bus_wdata_i[uart_bus_pkg::RegWidth-1:0];
      if (lcr_we) lcr_q <= bus_wdata_i[uart_bus_pkg::RegWidth-1:0];
      if (dll_we) dll_q <= bus_wdata_i[uart_bus_pkg::RegWidth-1:0];
      if (dlm_we) dlm_q <= bus_wdata_i[uart_bus_pkg::RegWidth-1:0];
      if (spr_we) spr_q <= bus_wdata_i[uart_bus_pkg::RegWidth-1:0];
      req_q   <= bus_req_i;
      we_q    <= bus_we_i;
      word_q  <= word_d;
      w_err_q <= w_err_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response phase
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lsr = '0;
    lsr[uart_line_pkg::LsrThreBit] = fifo_empty_i;
    lsr[uart_line_pkg::LsrTemtBit] = fifo_empty_i & ~tx_busy_i;  // Nothing left to send
  end

  // No receive path so a read of slot 0 with DLAB clear errors
  always_comb begin
    rd_byte = '0;
    r_err   = 1'b0;
    if (req_q && !we_q) begin
      case (word_q)
        uart_bus_pkg::IER_OFFSET: rd_byte = dlab ? dlm_q : ier_q;
        uart_bus_pkg::LCR_OFFSET: rd_byte = lcr_q;
        uart_bus_pkg::LSR_OFFSET: rd_byte = lsr;
        uart_bus_pkg::SPR_OFFSET: rd_byte = spr_q;
        uart_bus_pkg::DLL_OFFSET: begin
          rd_byte = dlab ? dll_q : '0;
          r_err   = ~dlab;
        end
        default:                  r_err   = 1'b1;
      endcase
    end
  end

  assign bus_rvalid_o = req_q;
  assign bus_rdata_o  = {{(uart_bus_pkg::BusDataWidth-uart_bus_pkg::RegWidth){1'b0}}, rd_byte};
  assign bus_err_o    = w_err_q | r_err;  // Writes zero data by construction
  assign divisor_o    = {dlm_q, dll_q};
  assign parity_en_o  = lcr_q[uart_line_pkg::LcrParityBit];

  // Accepted THR write lands in the FIFO by the next edge
  a_push_lands: assert property (@(posedge clk_i) disable iff (reset_i)
    push_valid_o |=> !fifo_empty_i);

endmodule

// ==== logic/uart_tx_fifo.sv ====
`timescale 1ns/1ps

module uart_tx_fifo (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       push_valid_i,
  input  logic [7:0] push_data_i,
  input  logic       tx_ack_i,
  output logic       fifo_full_o,
  output logic       fifo_empty_o,
  output logic       tx_req_o,
  output logic [7:0] tx_data_o
);

  logic [7:0]                              mem_q [uart_line_pkg::TxFifoDepth];
  logic [uart_line_pkg::TxFifoPtrWidth-1:0] wr_ptr_q, rd_ptr_q;  // Wrap naturally
  logic [uart_line_pkg::TxFifoPtrWidth:0]   count_q;
  logic                                     req_q;
  logic                                     open_q;  // Handshake cycle in progress
  logic                                     pop;

  assign pop          = req_q & tx_ack_i;  // Byte taken by the serializer
  assign fifo_empty_o = (count_q == '0);
  assign fifo_full_o  =
    (count_q == (uart_line_pkg::TxFifoPtrWidth+1)'(uart_line_pkg::TxFifoDepth));

  ////////////////////////////////////////////////////////////////////////////
  // Circular buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)          rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase pop side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      open_q <= 1'b0;
    end else if (!open_q && !tx_ack_i && !fifo_empty_o) begin
      req_q  <= 1'b1;  // Open a new cycle
      open_q <= 1'b1;
    end else if (pop) begin
      req_q  <= 1'b0;
    end else if (open_q && !req_q && !tx_ack_i) begin
      open_q <= 1'b0;  // Ack returned low, cycle closed
    end
  end

  assign tx_req_o  = req_q;
  assign tx_data_o = mem_q[rd_ptr_q];  // Head entry, untouched until pop

  // Full check lives in the register block
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_valid_i |-> !fifo_full_o);

  a_data_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_req_o |=> !tx_req_o || $stable(tx_data_o));

endmodule

// ==== logic/uart_tx_serializer.sv ====
`timescale 1ns/1ps

module uart_tx_serializer (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   tx_req_i,
  input  logic [7:0]                             tx_data_i,
  input  logic [uart_line_pkg::DivisorWidth-1:0] divisor_i,
  input  logic                                   parity_en_i,
  output logic                                   tx_ack_o,
  output logic                                   tx_busy_o,
  output logic                                   tx_o
);

  logic [10:0]                            shift_q;  // Frame image, LSB on the line
  logic [uart_line_pkg::DivisorWidth-1:0] baud_cnt_q;
  logic [3:0]                             bit_cnt_q;
  logic [3:0]                             last_bit_q;  // Index of the stop bit
  logic                                   ack_q;
  logic                                   busy_q;
  logic                                   take;
  logic                                   baud_tick;
  logic                                   parity;

  assign parity    = ^tx_data_i;  // Even parity over the data byte
  assign take      = tx_req_i & ~ack_q & ~busy_q;  // Only when idle
  assign baud_tick = busy_q & (baud_cnt_q == divisor_i);  // End of a bit

  ////////////////////////////////////////////////////////////////////////////
  // Ack side of the handshake
  ////////////////////////////////////////////////////////////////////////////

  // Runs on its own so ack can drop mid-frame
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else if (take) begin
      ack_q <= 1'b1;
    end else if (ack_q && !tx_req_i) begin
      ack_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame shifter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      shift_q    <= '1;  // Line idles high
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      last_bit_q <= '0;
      busy_q     <= 1'b0;
    end else if (take) begin
      // Parity slot doubles as a second stop level when unused
      shift_q    <= {1'b1, parity_en_i ? parity : 1'b1, tx_data_i, 1'b0};
      last_bit_q <= parity_en_i ? 4'd10 : 4'd9;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b1;
    end else if (busy_q) begin
      if (baud_tick) begin
        baud_cnt_q <= '0;
        shift_q    <= {1'b1, shift_q[10:1]};  // Refill with idle level
        bit_cnt_q  <= bit_cnt_q + 1'b1;
        if (bit_cnt_q == last_bit_q) begin
          busy_q <= 1'b0;  // Stop bit done
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  assign tx_o      = shift_q[0];
  assign tx_ack_o  = ack_q;
  assign tx_busy_o = busy_q;

  // New request from the FIFO only once ack is back low
  a_req_after_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(tx_req_i) |-> !tx_ack_o);

endmodule

// ==== logic/uart_tx_top.sv ====
`timescale 1ns/1ps

module uart_tx_top (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  bus_req_i,
  input  logic                                  bus_we_i,
  input  logic [uart_bus_pkg::BusAddrWidth-1:0] bus_addr_i,
  input  logic [uart_bus_pkg::BusDataWidth-1:0] bus_wdata_i,
  output logic                                  bus_gnt_o,
  output logic                                  bus_rvalid_o,
  output logic [uart_bus_pkg::BusDataWidth-1:0] bus_rdata_o,
  output logic                                  bus_err_o,
  output logic                                  tx_o
);

  // Push path, registers into FIFO
  logic       push_valid, fifo_full, fifo_empty;
  logic [7:0] push_data;
  // Pop path, FIFO into serializer
  logic       tx_req, tx_ack, tx_busy;
  logic [7:0] tx_data;
  // Line settings
  logic [uart_line_pkg::DivisorWidth-1:0] divisor;
  logic                                   parity_en;

  uart_regs i_regs (
    .clk_i, .reset_i, .bus_req_i, .bus_we_i, .bus_addr_i, .bus_wdata_i,
    .bus_gnt_o, .bus_rvalid_o, .bus_rdata_o, .bus_err_o,
    .push_valid_o (push_valid), .push_data_o (push_data),
    .divisor_o    (divisor),    .parity_en_o (parity_en),
    .fifo_full_i  (fifo_full),  .fifo_empty_i (fifo_empty), .tx_busy_i (tx_busy)
  );

  uart_tx_fifo i_fifo (
    .clk_i, .reset_i, .push_valid_i (push_valid), .push_data_i (push_data),
    .tx_ack_i (tx_ack), .fifo_full_o (fifo_full), .fifo_empty_o (fifo_empty),
    .tx_req_o (tx_req), .tx_data_o (tx_data)
  );

  uart_tx_serializer i_serializer (
    .clk_i, .reset_i, .tx_req_i (tx_req), .tx_data_i (tx_data),
    .divisor_i (divisor), .parity_en_i (parity_en),
    .tx_ack_o (tx_ack), .tx_busy_o (tx_busy), .tx_o
  );

endmodule

// ==== bench/uart_tx_tb.sv ====
`timescale 1ns/1ps

module uart_tx_tb;

  localparam int unsigned ClkPeriod  = 40;
  localparam int unsigned MaxDivisor = 3;    // Largest divisor any frame uses
  localparam int unsigned Margin     = 200;  // Reset and bus slack in cycles

  // Step kinds
  localparam logic [1:0] OpWr    = 2'd0;
  localparam logic [1:0] OpRd    = 2'd1;
  localparam logic [1:0] OpRnd   = 2'd2;  // THR write of a random byte
  localparam logic [1:0] OpDrain = 2'd3;  // Until every accepted byte left the line

  // Expected bus_err_o
  localparam logic [1:0] ErrNo  = 2'd0;
  localparam logic [1:0] ErrYes = 2'd1;
  localparam logic [1:0] ErrAny = 2'd2;  // FIFO full or not, taken from the response

  typedef struct {
    logic [1:0] op;
    logic [2:0] off;    // Word index
    logic [7:0] wdata;
    logic [7:0] rdata;  // Expected read byte
    logic [1:0] err;
  } step_t;

  logic                                  clk;
  logic                                  reset;
  logic                                  bus_req;
  logic                                  bus_we;
  logic [uart_bus_pkg::BusAddrWidth-1:0] bus_addr;
  logic [uart_bus_pkg::BusDataWidth-1:0] bus_wdata;
  logic                                  bus_gnt;
  logic                                  bus_rvalid;
  logic [uart_bus_pkg::BusDataWidth-1:0] bus_rdata;
  logic                                  bus_err;
  logic                                  tx;

  step_t       steps[$];
  logic [7:0]  expect_q[$];  // Accepted THR bytes in write order
  int unsigned errors;
  int unsigned frames;       // Decoded by the serial monitor
  int unsigned accepted;
  int unsigned dropped;
  logic [15:0] cur_div;      // Line settings as last programmed
  logic        cur_par;
  logic        dlab;
  integer      seed;

  uart_tx_top dut (
    .clk_i (clk), .reset_i (reset), .bus_req_i (bus_req), .bus_we_i (bus_we),
    .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata), .bus_gnt_o (bus_gnt),
    .bus_rvalid_o (bus_rvalid), .bus_rdata_o (bus_rdata), .bus_err_o (bus_err),
    .tx_o (tx)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic void add_step(logic [1:0] op, logic [2:0] off, logic [7:0] wdata,
                                   logic [7:0] rdata, logic [1:0] err);
    steps.push_back('{op, off, wdata, rdata, err});
  endfunction

  // Request on one falling edge, response sampled on the next
  task automatic bus_access(input logic we, input logic [2:0] off, input logic [7:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    assert (!bus_rvalid) else begin
      errors++;
      $display("A response arrived with no request pending before offset %0d", off);
    end
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = {off, 2'b00};
    bus_wdata = {24'h0, wdata};
    @(negedge clk);
    assert (bus_gnt && bus_rvalid) else begin
      errors++;
      $display("No grant or no response one cycle after the request to offset %0d", off);
    end
    rdata   = bus_rdata;
    err     = bus_err;
    bus_req = 1'b0;
  endtask

  // Mirror of the line settings and of the bytes owed to the line
  task automatic track_write(input logic [2:0] off, input logic [7:0] wdata, input logic err);
    if (off == uart_bus_pkg::THR_OFFSET && !dlab) begin
      if (err) begin
        dropped++;  // FIFO was full
      end else begin
        expect_q.push_back(wdata);
        accepted++;
      end
    end else if (!err) begin
      if (off == uart_bus_pkg::LCR_OFFSET) begin
        dlab    = wdata[uart_line_pkg::LcrDlabBit];
        cur_par = wdata[uart_line_pkg::LcrParityBit];
      end else if (dlab && off == uart_bus_pkg::DLL_OFFSET) begin
        cur_div[7:0] = wdata;
      end else if (dlab && off == uart_bus_pkg::DLM_OFFSET) begin
        cur_div[15:8] = wdata;
      end
    end
  endtask

  task automatic drain_line();
    while (frames < accepted) @(negedge clk);
    repeat (32'(cur_div) + 32'd1) @(negedge clk);  // Second half of the stop bit and more
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Serial monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin : serial_monitor
    logic [7:0]  data;
    logic [7:0]  exp_byte;
    logic        start_bit;
    logic        par_bit;
    logic        stop_bit;
    logic        par;
    int unsigned bit_cycles;
    int unsigned ones;
    @(negedge reset);
    forever begin
      @(negedge tx);  // Start bit begins
      bit_cycles = 32'(cur_div) + 32'd1;
      par        = cur_par;
      par_bit    = 1'b0;
      repeat ((bit_cycles + 1) / 2) @(negedge clk);  // Middle of the start bit
      start_bit = tx;
      for (int b = 0; b < 8; b++) begin
        repeat (bit_cycles) @(negedge clk);
        data[b] = tx;  // LSB first
      end
      if (par) begin
        repeat (bit_cycles) @(negedge clk);
        par_bit = tx;
      end
      repeat (bit_cycles) @(negedge clk);
      stop_bit = tx;
      assert (start_bit == 1'b0) else begin
        errors++;
        $display("Fail tx_o start bit: got %h, expected 0", start_bit);
      end
      assert (stop_bit == 1'b1) else begin
        errors++;
        $display("Fail tx_o stop bit: got %h, expected 1", stop_bit);
      end
      if (expect_q.size() == 0) begin
        errors++;
        $display("A frame appeared on tx_o with no byte written to THR");
      end else begin
        exp_byte = expect_q.pop_front();
        assert (data == exp_byte) else begin
          errors++;
          $display("Fail tx_o data: got %h, expected %h", data, exp_byte);
        end
        if (par) begin
          ones = 0;
          for (int b = 0; b < 8; b++) begin
            ones += exp_byte[b];
          end
          assert (((ones + par_bit) % 2) == 0) else begin  // Even count of ones with the bit
            errors++;
            $display("Fail tx_o parity: got %h, expected %h", par_bit, 1'(ones % 2));
          end
        end
      end
      frames++;
    end
  end

  initial begin : watchdog
    int unsigned limit;
    @(negedge reset);
    limit = (steps.size() * 11 * (MaxDivisor + 1) + Margin) * ClkPeriod;
    #(limit);
    $display("Watchdog expired at %0t and the run did not finish", $time);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Step table and main loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_steps
    step_t       s;
    logic [31:0] rdata;
    logic [31:0] exp_rd;
    logic [7:0]  wdata;
    logic        err;
    int          rnd;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    reset     = 1'b1;
    seed      = 32'h5acd;
    errors    = 0;
    frames    = 0;
    accepted  = 0;
    dropped   = 0;
    cur_div   = 16'd1;  // Reset divisor
    cur_par   = 1'b0;
    dlab      = 1'b0;
    // Reset values, LSR with THRE and TEMT
    add_step(OpRd, uart_bus_pkg::IER_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::LCR_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::SPR_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::LSR_OFFSET, 8'h00, 8'h60, ErrNo);
    // Divisor bank and its holes
    add_step(OpWr, uart_bus_pkg::LCR_OFFSET, 8'h80, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::DLL_OFFSET, 8'h34, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::DLM_OFFSET, 8'h12, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::DLL_OFFSET, 8'h00, 8'h34, ErrNo);
    add_step(OpRd, uart_bus_pkg::DLM_OFFSET, 8'h00, 8'h12, ErrNo);
    add_step(OpRd, 3'd2, 8'h00, 8'h00, ErrYes);
    add_step(OpWr, 3'd4, 8'h5a, 8'h00, ErrYes);
    add_step(OpWr, uart_bus_pkg::DLL_OFFSET, 8'h03, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::DLM_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::LCR_OFFSET, 8'h00, 8'h00, ErrNo);
    // Data bank on the same slots leaves the divisor alone
    add_step(OpWr, uart_bus_pkg::SPR_OFFSET, 8'ha5, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::SPR_OFFSET, 8'h00, 8'ha5, ErrNo);
    add_step(OpWr, uart_bus_pkg::IER_OFFSET, 8'h0f, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::IER_OFFSET, 8'h00, 8'h0f, ErrNo);
    add_step(OpWr, uart_bus_pkg::LCR_OFFSET, 8'h80, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::DLL_OFFSET, 8'h00, 8'h03, ErrNo);
    add_step(OpRd, uart_bus_pkg::DLM_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::LCR_OFFSET, 8'h00, 8'h00, ErrNo);
    // Unmapped, read only, and no receive path
    add_step(OpRd, 3'd6, 8'h00, 8'h00, ErrYes);
    add_step(OpWr, uart_bus_pkg::LSR_OFFSET, 8'hff, 8'h00, ErrYes);
    add_step(OpRd, uart_bus_pkg::THR_OFFSET, 8'h00, 8'h00, ErrYes);
    // Plain frames at divisor 3
    add_step(OpWr, uart_bus_pkg::THR_OFFSET, 8'h55, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::THR_OFFSET, 8'ha3, 8'h00, ErrNo);
    add_step(OpRnd, uart_bus_pkg::THR_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpDrain, 3'd0, 8'h00, 8'h00, ErrNo);
    // Even parity
    add_step(OpWr, uart_bus_pkg::LCR_OFFSET, 8'h08, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::THR_OFFSET, 8'h01, 8'h00, ErrNo);
    add_step(OpWr, uart_bus_pkg::THR_OFFSET, 8'h7e, 8'h00, ErrNo);
    add_step(OpRnd, uart_bus_pkg::THR_OFFSET, 8'h00, 8'h00, ErrNo);
    add_step(OpDrain, 3'd0, 8'h00, 8'h00, ErrNo);
    // Overflow burst, one in the serializer and four queued
    add_step(OpWr, uart_bus_pkg::LCR_OFFSET, 8'h00, 8'h00, ErrNo);
    for (int k = 1; k <= 6; k++) begin
      // An empty FIFO always takes the first four
      add_step(OpWr, uart_bus_pkg::THR_OFFSET, 8'(k * 17), 8'h00,
               (k <= uart_line_pkg::TxFifoDepth) ? ErrNo : ErrAny);
    end
    add_step(OpRd, uart_bus_pkg::LSR_OFFSET, 8'h00, 8'h00, ErrNo);  // Bytes still waiting
    add_step(OpDrain, 3'd0, 8'h00, 8'h00, ErrNo);
    add_step(OpRd, uart_bus_pkg::LSR_OFFSET, 8'h00, 8'h60, ErrNo);

    repeat (4) @(negedge clk);
    reset = 1'b0;
    assert (tx === 1'b1) else begin
      errors++;
      $display("Fail tx_o after reset: got %h, expected 1", tx);
    end

    foreach (steps[i]) begin
      s = steps[i];
      if (s.op == OpDrain) begin
        drain_line();
      end else begin
        wdata = s.wdata;
        if (s.op == OpRnd) begin
          rnd   = $random(seed);
          wdata = rnd[7:0];
        end
        bus_access(s.op != OpRd, s.off, wdata, rdata, err);
        exp_rd = (s.op == OpRd) ? {24'h0, s.rdata} : 32'h0;  // Errors and writes read zero
        assert (rdata == exp_rd) else begin
          errors++;
          $display("Fail bus_rdata_o: got %h, expected %h at step %0d", rdata, exp_rd, i);
        end
        if (s.err != ErrAny) begin
          assert (err == s.err[0]) else begin
            errors++;
            $display("Fail bus_err_o: got %h, expected %h at step %0d", err, s.err[0], i);
          end
        end
        if (s.op != OpRd) begin
          track_write(s.off, wdata, err);
        end
      end
    end

    assert (expect_q.size() == 0) else begin
      errors++;
      $display("%0d accepted bytes never appeared on tx_o", expect_q.size());
    end
    assert (dropped > 0) else begin
      errors++;
      $display("The overflow burst was accepted whole and no write was flagged");
    end
    $display("Errors: %0d, frames: %0d of %0d accepted, dropped writes: %0d",
             errors, frames, accepted, dropped);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
logic/uart_bus_pkg.sv
logic/uart_line_pkg.sv
logic/uart_regs.sv
logic/uart_tx_fifo.sv
logic/uart_tx_serializer.sv
logic/uart_tx_top.sv
bench/uart_tx_tb.sv

// ==== Makefile ====
SRCS := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vuart_tx_tb

obj_dir/Vuart_tx_tb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module uart_tx_tb -f build.f

run: obj_dir/Vuart_tx_tb
	@out="$$(./obj_dir/Vuart_tx_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
